// File: design/fetch_pkg.sv
package fetch_pkg;

    // instructions per fetch bundle
    localparam int FETCH_WIDTH = 4;

    // byte address of an instruction
    typedef logic [31:0] addr_t;

    // raw instruction word
    typedef logic [31:0] inst_t;

    // memory transaction tag
    // zero is refused on request, no data on response
    typedef logic [3:0] mem_tag_t;

    // one memory block, two instructions
    // word at address bit 2 = 0 sits in the low half
    typedef logic [63:0] mem_block_t;

    // redirect from the back end
    // taken keeps buffered instructions, squash flushes buffer and MSHRs
    typedef enum logic [1:0] {
        BR_NONE   = 2'd0,
        BR_TAKEN  = 2'd1,
        BR_SQUASH = 2'd2
    } br_task_t;

endpackage

// File: design/icache.sv
`timescale 1ns/1ps

module icache #(
    parameter int ICACHE_LINES = 16
) (
    input  logic                         clock,
    input  logic                         rst_n,

    // lookup of the fetch PC block and the block after it
    input  fetch_pkg::addr_t             lookup_addr,

    // refill port from the MSHR side
    input  logic                         write_en,
    input  fetch_pkg::addr_t             write_addr,
    input  fetch_pkg::mem_block_t        write_data,

    // index 0 is the PC block, index 1 the next block
    output fetch_pkg::mem_block_t [1:0]  cache_blocks,
    output logic [1:0]                   cache_valid
);

    // block number is address bits 31:3
    localparam int IW = $clog2(ICACHE_LINES);
    localparam int TW = 29 - IW;

    // line storage
    fetch_pkg::mem_block_t data_q [ICACHE_LINES];
    logic [TW-1:0]         tag_q  [ICACHE_LINES];
    logic [ICACHE_LINES-1:0] valid_q;

    // lookup side
    logic [1:0][28:0]   look_blk;
    logic [1:0][IW-1:0] look_idx;

    // refill side
    logic [28:0]   wr_blk;
    logic [IW-1:0] wr_idx;

    // two lookups per cycle, purely combinational
    always_comb begin
        look_blk[0] = lookup_addr[31:3];
        // next sequential block, may land on the neighbouring line
        look_blk[1] = lookup_addr[31:3] + 29'd1;
        for (int k = 0; k < 2; k++) begin
            look_idx[k]     = look_blk[k][IW-1:0];
            cache_blocks[k] = data_q[look_idx[k]];
            // hit needs a valid line holding the same tag
            cache_valid[k]  = valid_q[look_idx[k]] &&
                              (tag_q[look_idx[k]] == look_blk[k][28:IW]);
        end
    end

    assign wr_blk = write_addr[31:3];
    assign wr_idx = wr_blk[IW-1:0];

    // valid bits, cleared only by reset
    // a squash leaves the cache contents alone
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (write_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // refill overwrites whatever the line held
    always_ff @(posedge clock) begin
        if (write_en) begin
            data_q[wr_idx] <= write_data;
            tag_q[wr_idx]  <= wr_blk[28:IW];
        end
    end

endmodule

// File: design/fetch.sv
`timescale 1ns/1ps

module fetch #(
    parameter int NUM_MEM_TAGS    = 15,
    parameter int INST_BUFF_DEPTH = 8
) (
    input  logic                                             clock,
    input  logic                                             rst_n,
    input  fetch_pkg::br_task_t                              br_task,
    input  fetch_pkg::addr_t                                 target,
    input  fetch_pkg::mem_tag_t                              mem_transaction_tag,
    input  fetch_pkg::mem_tag_t                              mem_data_tag,
    input  fetch_pkg::mem_block_t                            mem_data,
    input  fetch_pkg::mem_block_t [1:0]                      cache_blocks,
    input  logic [1:0]                                       cache_valid,
    input  logic [$clog2(INST_BUFF_DEPTH+1)-1:0]             open_count,
    output logic                                             mem_en,
    output fetch_pkg::addr_t                                 mem_addr,
    output fetch_pkg::addr_t                                 lookup_addr,
    output logic                                             write_en,
    output fetch_pkg::addr_t                                 write_addr,
    output fetch_pkg::mem_block_t                            write_data,
    output fetch_pkg::inst_t [fetch_pkg::FETCH_WIDTH-1:0]    bundle_insts,
    output fetch_pkg::addr_t [fetch_pkg::FETCH_WIDTH-1:0]    bundle_pcs,
    output logic [2:0]                                       bundle_count
);

    localparam int OW = $clog2(INST_BUFF_DEPTH+1);

    // fetch PC, idle until the first redirect
    fetch_pkg::addr_t pc;
    logic             active;
    logic             redirect;

    // MSHRs, one per memory tag, tag 0 unused
    fetch_pkg::addr_t [NUM_MEM_TAGS:1] mshr_addr;
    logic [NUM_MEM_TAGS:1]             mshr_valid;

    // miss selection
    fetch_pkg::addr_t [1:0] blk_addr;
    logic [1:0]             in_mshr;
    logic [1:0]             need;
    logic                   req_ok;
    logic                   resp_hit;

    // bundle assembly
    logic [2:0]  raw_count;
    logic [2:0]  next_count;
    logic [OW-1:0] room;
    fetch_pkg::inst_t [fetch_pkg::FETCH_WIDTH-1:0] next_insts;
    fetch_pkg::addr_t [fetch_pkg::FETCH_WIDTH-1:0] next_pcs;

    assign redirect    = (br_task != fetch_pkg::BR_NONE);
    assign lookup_addr = pc;

    // pick one miss per cycle, PC block before next block
    always_comb begin
        blk_addr[0] = {pc[31:3], 3'b000};
        blk_addr[1] = blk_addr[0] + 32'd8;
        in_mshr     = 2'b00;
        for (int j = 1; j <= NUM_MEM_TAGS; j++) begin
            for (int k = 0; k < 2; k++) begin
                if (mshr_valid[j] && (mshr_addr[j][31:3] == blk_addr[k][31:3])) begin
                    in_mshr[k] = 1'b1;
                end
            end
        end
        need     = ~cache_valid & ~in_mshr;
        // no request while the PC is being replaced or all tags are busy
        mem_en   = active && !redirect && !(&mshr_valid) && (need != 2'b00);
        mem_addr = need[0] ? blk_addr[0] : blk_addr[1];
    end

    // tag 0 back from memory means it refused
    assign req_ok = mem_en && (mem_transaction_tag != '0) &&
                    (int'(mem_transaction_tag) <= NUM_MEM_TAGS);

    // response routing, unknown tags are dropped here
    always_comb begin
        resp_hit   = 1'b0;
        write_addr = '0;
        if ((mem_data_tag != '0) && (int'(mem_data_tag) <= NUM_MEM_TAGS)) begin
            resp_hit   = mshr_valid[mem_data_tag];
            write_addr = mshr_addr[mem_data_tag];
        end
    end

    assign write_en   = resp_hit;
    assign write_data = mem_data;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            mshr_valid <= '0;
        end else if (br_task == fetch_pkg::BR_SQUASH) begin
            // late responses of the old path find no MSHR
            mshr_valid <= '0;
        end else begin
            if (resp_hit) begin
                mshr_valid[mem_data_tag] <= 1'b0;
            end
            // a tag freed and reissued in one cycle ends up valid
            if (req_ok) begin
                mshr_valid[mem_transaction_tag] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (req_ok) begin
            mshr_addr[mem_transaction_tag] <= mem_addr;
        end
    end

    // bundle size and contents from the two looked-up blocks
    always_comb begin
        logic [2:0] word;
        raw_count = 3'd0;
        if (cache_valid[0]) begin
            raw_count = pc[2] ? 3'd1 : 3'd2;
            if (cache_valid[1]) begin
                raw_count = raw_count + 3'd2;
            end
        end
        // bundle on the wires is not in open_count yet
        room       = open_count - OW'(bundle_count);
        next_count = raw_count;
        if (OW'(raw_count) > room) begin
            next_count = 3'(room);
        end
        // nothing fetched in the redirect cycle
        if (!active || redirect) begin
            next_count = 3'd0;
        end
        for (int i = 0; i < fetch_pkg::FETCH_WIDTH; i++) begin
            // word offset from the PC block start, bit 1 picks the block
            word          = 3'(pc[2]) + 3'(i);
            next_pcs[i]   = pc + 32'(4 * i);
            next_insts[i] = word[0] ? cache_blocks[word[1]][63:32]
                                    : cache_blocks[word[1]][31:0];
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc           <= '0;
            active       <= 1'b0;
            bundle_count <= 3'd0;
        end else begin
            bundle_count <= next_count;
            if (redirect) begin
                pc     <= {target[31:2], 2'b00};
                active <= 1'b1;
            end else begin
                pc <= pc + {27'd0, next_count, 2'b00};
            end
        end
    end

    // slots past bundle_count are don't care
    always_ff @(posedge clock) begin
        bundle_insts <= next_insts;
        bundle_pcs   <= next_pcs;
    end

endmodule

// File: design/inst_buffer.sv
`timescale 1ns/1ps

module inst_buffer #(
    parameter int INST_BUFF_DEPTH = 8
) (
    input  logic                                             clock,
    input  logic                                             rst_n,
    input  fetch_pkg::br_task_t                              br_task,
    input  fetch_pkg::inst_t [fetch_pkg::FETCH_WIDTH-1:0]    bundle_insts,
    input  fetch_pkg::addr_t [fetch_pkg::FETCH_WIDTH-1:0]    bundle_pcs,
    input  logic [2:0]                                       bundle_count,
    input  logic                                             dispatch_ready,
    output logic [$clog2(INST_BUFF_DEPTH+1)-1:0]             open_count,
    output logic                                             dispatch_valid,
    output fetch_pkg::inst_t                                 dispatch_inst,
    output fetch_pkg::addr_t                                 dispatch_pc
);

    localparam int PW = $clog2(INST_BUFF_DEPTH);
    localparam int OW = $clog2(INST_BUFF_DEPTH+1);

    // entry storage
    fetch_pkg::inst_t insts_q [INST_BUFF_DEPTH];
    fetch_pkg::addr_t pcs_q   [INST_BUFF_DEPTH];

    logic [PW-1:0] head;
    logic [PW-1:0] tail;
    logic [OW-1:0] occ;

    logic       squash;
    logic       pop;
    logic [2:0] push_count;

    // pointer advance with wrap, depth need not be a power of two
    function automatic logic [PW-1:0] wrap_add(input logic [PW-1:0] base,
                                               input int unsigned step);
        int unsigned sum;
        sum = int'(base) + step;
        if (sum >= INST_BUFF_DEPTH) begin
            sum = sum - INST_BUFF_DEPTH;
        end
        return PW'(sum);
    endfunction

    assign squash     = (br_task == fetch_pkg::BR_SQUASH);
    // bundle arriving with a squash belongs to the old path
    assign push_count = squash ? 3'd0 : bundle_count;

    assign dispatch_valid = (occ != '0);
    assign pop            = dispatch_valid && dispatch_ready;
    assign dispatch_inst  = insts_q[head];
    assign dispatch_pc    = pcs_q[head];
    assign open_count     = OW'(INST_BUFF_DEPTH) - occ;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            head <= '0;
            tail <= '0;
            occ  <= '0;
        end else if (squash) begin
            head <= '0;
            tail <= '0;
            occ  <= '0;
        end else begin
            // push and pop may happen in the same cycle
            if (pop) begin
                head <= wrap_add(head, 1);
            end
            tail <= wrap_add(tail, push_count);
            occ  <= occ + OW'(push_count) - OW'(pop);
        end
    end

    // write the first bundle_count slots at the tail
    always_ff @(posedge clock) begin
        for (int i = 0; i < fetch_pkg::FETCH_WIDTH; i++) begin
            if (i < push_count) begin
                insts_q[wrap_add(tail, i)] <= bundle_insts[i];
                pcs_q[wrap_add(tail, i)]   <= bundle_pcs[i];
            end
        end
    end

endmodule

// File: design/fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
    parameter int NUM_MEM_TAGS    = 15,
    parameter int ICACHE_LINES    = 16,
    parameter int INST_BUFF_DEPTH = 8
) (
    input  logic                    clock,
    input  logic                    rst_n,
    input  fetch_pkg::br_task_t     br_task,
    input  fetch_pkg::addr_t        target,
    input  fetch_pkg::mem_tag_t     mem_transaction_tag,
    input  fetch_pkg::mem_tag_t     mem_data_tag,
    input  fetch_pkg::mem_block_t   mem_data,
    input  logic                    dispatch_ready,
    output logic                    mem_en,
    output fetch_pkg::addr_t        mem_addr,
    output logic                    dispatch_valid,
    output fetch_pkg::inst_t        dispatch_inst,
    output fetch_pkg::addr_t        dispatch_pc
);

    // cache lookup and refill
    fetch_pkg::addr_t             lookup_addr;
    fetch_pkg::mem_block_t [1:0]  cache_blocks;
    logic [1:0]                   cache_valid;
    logic                         write_en;
    fetch_pkg::addr_t             write_addr;
    fetch_pkg::mem_block_t        write_data;

    // fetch to buffer bundle and free space back
    fetch_pkg::inst_t [fetch_pkg::FETCH_WIDTH-1:0] bundle_insts;
    fetch_pkg::addr_t [fetch_pkg::FETCH_WIDTH-1:0] bundle_pcs;
    logic [2:0]                                    bundle_count;
    logic [$clog2(INST_BUFF_DEPTH+1)-1:0]          open_count;

    fetch #(
        .NUM_MEM_TAGS        (NUM_MEM_TAGS),
        .INST_BUFF_DEPTH     (INST_BUFF_DEPTH)
    ) u_fetch (
        .clock               (clock),
        .rst_n               (rst_n),
        .br_task             (br_task),
        .target              (target),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data_tag        (mem_data_tag),
        .mem_data            (mem_data),
        .cache_blocks        (cache_blocks),
        .cache_valid         (cache_valid),
        .open_count          (open_count),
        .mem_en              (mem_en),
        .mem_addr            (mem_addr),
        .lookup_addr         (lookup_addr),
        .write_en            (write_en),
        .write_addr          (write_addr),
        .write_data          (write_data),
        .bundle_insts        (bundle_insts),
        .bundle_pcs          (bundle_pcs),
        .bundle_count        (bundle_count)
    );

    icache #(
        .ICACHE_LINES        (ICACHE_LINES)
    ) u_icache (
        .clock               (clock),
        .rst_n               (rst_n),
        .lookup_addr         (lookup_addr),
        .write_en            (write_en),
        .write_addr          (write_addr),
        .write_data          (write_data),
        .cache_blocks        (cache_blocks),
        .cache_valid         (cache_valid)
    );

    inst_buffer #(
        .INST_BUFF_DEPTH     (INST_BUFF_DEPTH)
    ) u_inst_buffer (
        .clock               (clock),
        .rst_n               (rst_n),
        .br_task             (br_task),
        .bundle_insts        (bundle_insts),
        .bundle_pcs          (bundle_pcs),
        .bundle_count        (bundle_count),
        .dispatch_ready      (dispatch_ready),
        .open_count          (open_count),
        .dispatch_valid      (dispatch_valid),
        .dispatch_inst       (dispatch_inst),
        .dispatch_pc         (dispatch_pc)
    );

endmodule

// File: dv/mem_model.sv
`timescale 1ns/1ps

module mem_model #(
    parameter int MEM_LATENCY = 6
) (
    input  logic                  clock,
    input  logic                  rst_n,
    // forces tag 0 on every request
    input  logic                  refuse,
    input  logic                  mem_en,
    input  fetch_pkg::addr_t      mem_addr,
    output fetch_pkg::mem_tag_t   mem_transaction_tag,
    output fetch_pkg::mem_tag_t   mem_data_tag,
    output fetch_pkg::mem_block_t mem_data
);

    // tags in flight
    // tag 0 is never handed out
    logic [15:1]         busy;
    fetch_pkg::mem_tag_t free_tag;
    int                  cycle;

    // accepted requests in order
    // fixed latency keeps the responses in that order
    fetch_pkg::mem_tag_t q_tag  [$];
    fetch_pkg::addr_t    q_addr [$];
    int                  q_due  [$];

    initial begin
        busy         = '0;
        cycle        = 0;
        mem_data_tag = '0;
        mem_data     = '0;
    end

    // lowest tag not outstanding or 0 when all are busy
    always_comb begin
        free_tag = '0;
        for (int t = 15; t >= 1; t--) begin
            if (!busy[t]) begin
                free_tag = 4'(t);
            end
        end
    end

    // tag answer is combinational in the request cycle
    assign mem_transaction_tag = (mem_en && !refuse) ? free_tag : '0;

    always @(posedge clock) begin
        logic                take;
        fetch_pkg::mem_tag_t take_tag;
        fetch_pkg::addr_t    take_addr;
        fetch_pkg::addr_t    resp_addr;
        // sample the request at the edge and update a little later
        take      = rst_n && (mem_transaction_tag != '0);
        take_tag  = mem_transaction_tag;
        take_addr = mem_addr;
        #1;
        cycle++;
        if (!rst_n) begin
            busy = '0;
            q_tag.delete();
            q_addr.delete();
            q_due.delete();
            mem_data_tag = '0;
        end else begin
            // response shown last cycle was consumed at this edge
            if (mem_data_tag != '0) begin
                busy[mem_data_tag] = 1'b0;
            end
            mem_data_tag = '0;
            if (take) begin
                busy[take_tag] = 1'b1;
                q_tag.push_back(take_tag);
                q_addr.push_back(take_addr);
                q_due.push_back(cycle + MEM_LATENCY - 1);
            end
            // at most one response per cycle
            // oldest first
            if ((q_due.size() > 0) && (q_due[0] <= cycle)) begin
                mem_data_tag = q_tag.pop_front();
                resp_addr    = q_addr.pop_front();
                q_due.delete(0);
                // word at bit 2 = 0 in the low half
                mem_data     = {(resp_addr + 32'd4) ^ 32'h5a5a0000,
                                resp_addr ^ 32'h5a5a0000};
            end
        end
    end

endmodule

// File: dv/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

    localparam int NUM_MEM_TAGS    = 15;
    localparam int ICACHE_LINES    = 16;
    localparam int INST_BUFF_DEPTH = 8;
    localparam int MEM_LATENCY     = 6;

    // instructions waited for in each test
    localparam int N_COLD   = 64;
    localparam int N_TAKEN  = INST_BUFF_DEPTH + 32;
    localparam int N_SQUASH = 32;
    localparam int N_BP     = 32;
    localparam int N_REFUSE = 32;
    localparam int N_RANDOM = 300;
    // cycles with dispatch or memory held off
    localparam int N_HOLD   = 32 + 3 + 40 + 30;
    localparam int N_TOTAL  = N_COLD + N_TAKEN + N_SQUASH + N_BP + N_REFUSE + N_RANDOM;
    // a cold block pair costs about MEM_LATENCY + 4 cycles for four instructions
    // random ready halves the rate
    // ten cycles per instruction leaves margin
    localparam int TIMEOUT_CYCLES = 10 * N_TOTAL + N_HOLD + 200;

    logic                  clock;
    logic                  rst_n;
    fetch_pkg::br_task_t   br_task;
    fetch_pkg::addr_t      target;
    logic                  refuse;
    fetch_pkg::mem_tag_t   mem_transaction_tag;
    fetch_pkg::mem_tag_t   mem_data_tag;
    fetch_pkg::mem_block_t mem_data;
    logic                  dispatch_ready;
    logic                  mem_en;
    fetch_pkg::addr_t      mem_addr;
    logic                  dispatch_valid;
    fetch_pkg::inst_t      dispatch_inst;
    fetch_pkg::addr_t      dispatch_pc;

    // reference stream state
    fetch_pkg::addr_t exp_pc;
    // taken targets not yet seen on the dispatch port
    fetch_pkg::addr_t pend [$];
    int               drained;
    int               drain_expect;
    int               n_disp;
    int               errors;
    int               cycles;
    integer           seed;

    fetch_top #(
        .NUM_MEM_TAGS        (NUM_MEM_TAGS),
        .ICACHE_LINES        (ICACHE_LINES),
        .INST_BUFF_DEPTH     (INST_BUFF_DEPTH)
    ) DUT (
        .clock               (clock),
        .rst_n               (rst_n),
        .br_task             (br_task),
        .target              (target),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data_tag        (mem_data_tag),
        .mem_data            (mem_data),
        .dispatch_ready      (dispatch_ready),
        .mem_en              (mem_en),
        .mem_addr            (mem_addr),
        .dispatch_valid      (dispatch_valid),
        .dispatch_inst       (dispatch_inst),
        .dispatch_pc         (dispatch_pc)
    );

    mem_model #(
        .MEM_LATENCY         (MEM_LATENCY)
    ) u_mem (
        .clock               (clock),
        .rst_n               (rst_n),
        .refuse              (refuse),
        .mem_en              (mem_en),
        .mem_addr            (mem_addr),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data_tag        (mem_data_tag),
        .mem_data            (mem_data)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // reference stream checker
    // the dispatch at an edge is checked before that edge's redirect
    always @(posedge clock) begin
        int hit;
        if (rst_n) begin
            if (mem_en) begin
                assert (mem_addr[2:0] == 3'b000) else begin
                    errors++;
                    $display("[FAIL] %0t mem_addr %h not block aligned", $time, mem_addr);
                end
            end
            if (dispatch_valid && dispatch_ready) begin
                hit = -1;
                for (int k = 0; k < pend.size(); k++) begin
                    if ((hit < 0) && (dispatch_pc == pend[k])) begin
                        hit = k;
                    end
                end
                // old path is done and the stream goes on from that taken target
                if (hit >= 0) begin
                    assert (drained <= INST_BUFF_DEPTH) else begin
                        errors++;
                        $display("[FAIL] %0t %0d old-path instructions after taken",
                                 $time, drained);
                    end
                    if (drain_expect >= 0) begin
                        assert (drained == drain_expect) else begin
                            errors++;
                            $display("[FAIL] %0t drained %0d before target, expected %0d",
                                     $time, drained, drain_expect);
                        end
                    end
                    exp_pc       = pend[hit];
                    drain_expect = -1;
                    for (int k = 0; k <= hit; k++) begin
                        pend.delete(0);
                    end
                end
                assert (dispatch_inst == (exp_pc ^ 32'h5a5a0000)) else begin
                    errors++;
                    $display("[FAIL] %0t inst %h, expected %h", $time,
                             dispatch_inst, exp_pc ^ 32'h5a5a0000);
                end
                assert (dispatch_pc == exp_pc) else begin
                    errors++;
                    $display("[FAIL] %0t pc %h, expected %h", $time, dispatch_pc, exp_pc);
                    // reference follows the dispatched pc from here on
                    exp_pc = dispatch_pc;
                end
                exp_pc = exp_pc + 32'd4;
                n_disp++;
                drained++;
            end
            if (br_task == fetch_pkg::BR_SQUASH) begin
                exp_pc       = {target[31:2], 2'b00};
                drain_expect = -1;
                drained      = 0;
                pend.delete();
            end else if (br_task == fetch_pkg::BR_TAKEN) begin
                pend.push_back({target[31:2], 2'b00});
                drained = 0;
            end
        end
    end

    // run limit
    always @(posedge clock) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("errors: %0d, instructions dispatched: %0d", errors, n_disp);
            $display("Verification failed");
            $finish;
        end
    end

    // to just after the next rising edge
    task automatic step();
        @(posedge clock);
        #1;
    endtask

    // one-cycle redirect pulse
    task automatic redirect(input fetch_pkg::br_task_t kind, input fetch_pkg::addr_t addr);
        br_task = kind;
        target  = addr;
        step();
        br_task = fetch_pkg::BR_NONE;
    endtask

    task automatic wait_dispatches(input int n);
        int goal;
        goal = n_disp + n;
        while (n_disp < goal) begin
            step();
        end
    endtask

    task automatic cold_start();
        // idle until the first redirect
        repeat (4) step();
        assert (!mem_en && !dispatch_valid) else begin
            errors++;
            $display("[FAIL] %0t fetch active before any redirect", $time);
        end
        redirect(fetch_pkg::BR_SQUASH, 32'h1000);
        wait_dispatches(N_COLD);
    endtask

    task automatic taken_redirect();
        // with a full buffer and nothing in flight exactly DEPTH old instructions drain
        dispatch_ready = 1'b0;
        repeat (32) step();
        drain_expect = INST_BUFF_DEPTH;
        redirect(fetch_pkg::BR_TAKEN, 32'h3004);
        dispatch_ready = 1'b1;
        wait_dispatches(N_TAKEN);
        assert (pend.size() == 0) else begin
            errors++;
            $display("[FAIL] %0t taken target 3004 never dispatched", $time);
        end
    endtask

    task automatic squash_during_refill();
        redirect(fetch_pkg::BR_SQUASH, 32'h5000);
        // 0x5000 refills still outstanding here
        repeat (3) step();
        redirect(fetch_pkg::BR_SQUASH, 32'h6000);
        wait_dispatches(N_SQUASH);
    endtask

    task automatic back_pressure();
        logic seen_valid;
        seen_valid     = 1'b0;
        dispatch_ready = 1'b0;
        repeat (40) begin
            step();
            // once offered it must stay offered
            if (seen_valid) begin
                assert (dispatch_valid) else begin
                    errors++;
                    $display("[FAIL] %0t dispatch_valid dropped under back-pressure", $time);
                end
            end
            seen_valid = seen_valid || dispatch_valid;
        end
        dispatch_ready = 1'b1;
        wait_dispatches(N_BP);
    endtask

    task automatic memory_refusal();
        refuse = 1'b1;
        // every block of this cold region needs memory
        redirect(fetch_pkg::BR_SQUASH, 32'h9000);
        repeat (30) begin
            step();
            assert (!dispatch_valid) else begin
                errors++;
                $display("[FAIL] %0t dispatch while memory refuses", $time);
            end
        end
        refuse = 1'b0;
        wait_dispatches(N_REFUSE);
    endtask

    task automatic random_traffic();
        int               goal;
        int               rnd;
        int               cooldown;
        fetch_pkg::addr_t region;
        goal     = n_disp + N_RANDOM;
        cooldown = 0;
        region   = 32'h0001_0000;
        while (n_disp < goal) begin
            rnd            = $random(seed);
            dispatch_ready = rnd[0];
            // about one redirect in sixteen cycles with at least twelve between
            if ((cooldown == 0) && (rnd[7:4] == 4'd0)) begin
                cooldown = 12;
                // each target opens a fresh 4 KB region the old paths never reach
                region   = region + 32'h1000;
                redirect(fetch_pkg::BR_TAKEN, region + {22'd0, rnd[15:8], 2'b00});
            end else begin
                if (cooldown > 0) begin
                    cooldown--;
                end
                step();
            end
        end
        dispatch_ready = 1'b1;
    endtask

    initial begin
        seed           = 32'h0b443701;
        rst_n          = 1'b0;
        br_task        = fetch_pkg::BR_NONE;
        target         = '0;
        refuse         = 1'b0;
        dispatch_ready = 1'b1;
        exp_pc         = '0;
        drained        = 0;
        drain_expect   = -1;
        n_disp         = 0;
        errors         = 0;
        cycles         = 0;
        repeat (8) @(posedge clock);
        #1;
        rst_n = 1'b1;
        cold_start();
        taken_redirect();
        squash_during_refill();
        back_pressure();
        memory_refusal();
        random_traffic();
        $display("errors: %0d, instructions dispatched: %0d", errors, n_disp);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: build.f
design/fetch_pkg.sv
design/icache.sv
design/fetch.sv
design/inst_buffer.sv
design/fetch_top.sv
dv/mem_model.sv
dv/fetch_tb.sv
